/* sources.f */
hdl/gpio_pkg.sv
hdl/apb_reg_decode.sv
hdl/gpio_pin_cell.sv
hdl/apb_read_mux.sv
hdl/gpio_apb_top.sv
tb/tb_clock_gen.sv
tb/gpio_apb_asserts.sv
tb/gpio_apb_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the GPIO APB testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   -f sources.f \
   --top-module gpio_apb_tb \
   -o gpio_apb_sim

out=$(./obj_dir/gpio_apb_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Done: no errors"; then
   exit 0
fi
exit 1

/* tb/gpio_apb_tb.sv */
`timescale 1ns/1ps

module gpio_apb_tb;

   import gpio_pkg::*;

   typedef enum logic [2:0] {
      op_write, op_read, op_read_cfg, op_drive, op_wait, op_check, op_end
   } op_t;

   typedef enum logic [1:0] {sel_out, sel_oe, sel_int, sel_int_or} sel_t;

   typedef struct packed {
      op_t                   op;
      sel_t                  sel;
      logic [apb_addr_w-1:0] addr;
      logic [apb_data_w-1:0] data;
      logic [apb_data_w-1:0] exp;
   } entry_t;

   localparam int mask_out = 0;
   localparam int mask_oe  = 1;
   localparam int mask_in  = 2;

   // pins used by the interrupt tests
   localparam int p_pos  = 3;
   localparam int p_neg  = 9;
   localparam int p_both = 17;
   localparam int p_hi   = 5;
   localparam int p_lo   = 12;
   localparam int p_off  = 20;

   logic                  PCLK;
   logic                  aresetn;
   logic                  psel;
   logic                  penable;
   logic                  pwrite;
   logic [apb_addr_w-1:0] paddr;
   logic [apb_data_w-1:0] pwdata;
   logic [apb_data_w-1:0] prdata;
   logic                  pready;
   logic                  pslverr;
   logic [gpio_pins-1:0]  gpio_in;
   logic [gpio_pins-1:0]  gpio_out;
   logic [gpio_pins-1:0]  gpio_oe;
   logic [gpio_pins-1:0]  int_vec;
   logic                  int_or;

   entry_t      table_q [$];
   pin_cfg_t    cfg_m [gpio_pins];
   logic [31:0] lcg_state;
   int          table_cycles;
   int          cycle_limit;
   int          cycle_cnt;
   int          test_checks;
   int          test_errors;
   int          total_checks;
   int          total_errors;
   string       test_names [6] = '{"reset", "config", "outputs", "inputs",
                                   "edge_int", "level_int"};

   tb_clock_gen u_clk (
      .PCLK    (PCLK),
      .aresetn (aresetn)
   );

   gpio_apb_top dut0 (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_vec),
      .int_or_o   (int_or)
   );

   // ----------------------------------------
   // stimulus helpers and reference model
   // ----------------------------------------
   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic logic [31:0] pin_bit(int p);
      return 32'h1 << p;
   endfunction

   function automatic logic [31:0] en_mask(int which);
      logic [31:0] m;
      for (int i = 0; i < gpio_pins; i++)
      begin
         case (which)
            mask_out: m[i] = cfg_m[i].out_en;
            mask_oe:  m[i] = cfg_m[i].oe_en & cfg_m[i].out_en;
            default:  m[i] = cfg_m[i].in_en;
         endcase
      end
      return m;
   endfunction

   function automatic void add_op(op_t op, sel_t sel, logic [7:0] addr,
                                  logic [31:0] data, logic [31:0] exp, int cycles);
      entry_t e;
      e.op   = op;
      e.sel  = sel;
      e.addr = addr;
      e.data = data;
      e.exp  = exp;
      table_q.push_back(e);
      table_cycles += cycles;
   endfunction

   function automatic void write_cfg(int pin, pin_cfg_t c);
      cfg_m[pin] = c;
      add_op(op_write, sel_out, 8'(pin * 4), {24'h0, c}, '0, 3);
   endfunction

   function automatic void disable_int(int pin);
      pin_cfg_t c;
      c = cfg_m[pin];
      c.int_en = 1'b0;
      write_cfg(pin, c);
   endfunction

   function automatic void add_check(sel_t sel, logic [31:0] exp);
      add_op(op_check, sel, '0, '0, exp, 1);
   endfunction

   function automatic void add_read(logic [7:0] addr, logic [31:0] exp);
      add_op(op_read, sel_out, addr, '0, exp, 3);
   endfunction

   function automatic void add_drive(logic [31:0] v);
      add_op(op_drive, sel_out, '0, v, '0, 1);
   endfunction

   function automatic void add_wait(int n);
      add_op(op_wait, sel_out, '0, 32'(n), '0, n);
   endfunction

   function automatic void build_table();
      pin_cfg_t    c;
      logic [31:0] r;
      logic [31:0] v;
      int          pins [8];
      for (int i = 0; i < gpio_pins; i++)
         cfg_m[i] = '0;

      // reset values
      for (int i = 0; i < gpio_pins; i++)
         add_op(op_read_cfg, sel_out, 8'(i * 4), '0, '0, 3);
      add_read(addr_gpout, gpout_reset_val);
      add_check(sel_out, '0);
      add_check(sel_oe, '0);
      add_check(sel_int, '0);
      add_check(sel_int_or, '0);
      add_op(op_end, sel_out, '0, 32'd0, '0, 0);

      // config readback, pins may repeat
      for (int k = 0; k < 8; k++)
      begin
         r = next_rand();
         pins[k] = int'(r[12:8]);
         write_cfg(pins[k], pin_cfg_t'(r[7:0]));
      end
      for (int k = 0; k < 8; k++)
         add_op(op_read_cfg, sel_out, 8'(pins[k] * 4), '0, {24'h0, cfg_m[pins[k]]}, 3);
      add_read(8'h84, '0);
      add_read(8'h94, '0);
      add_read(8'hB0, '0);
      add_read(8'hFC, '0);
      add_op(op_end, sel_out, '0, 32'd1, '0, 0);

      // outputs
      for (int k = 0; k < 8; k++)
      begin
         r = next_rand();
         write_cfg(int'(r[12:8]), pin_cfg_t'(r[7:0]));
      end
      v = next_rand();
      add_op(op_write, sel_out, addr_gpout, v, '0, 3);
      add_check(sel_out, v & en_mask(mask_out));
      add_check(sel_oe, en_mask(mask_oe));
      add_read(addr_gpout, v);
      add_op(op_end, sel_out, '0, 32'd2, '0, 0);

      // inputs
      for (int k = 0; k < 2; k++)
      begin
         v = next_rand();
         add_drive(v);
         add_wait(3);
         add_read(addr_gpin, v & en_mask(mask_in));
      end
      add_op(op_end, sel_out, '0, 32'd3, '0, 0);

      // ----------------------------------------
      // edge interrupts
      // ----------------------------------------
      add_drive('0);
      add_wait(4);
      for (int i = 0; i < gpio_pins; i++)
      begin
         if (cfg_m[i].int_en)
            disable_int(i);
      end
      c = '0;
      c.in_en  = 1'b1;
      c.int_en = 1'b1;
      c.int_type = int_edge_pos;
      write_cfg(p_pos, c);
      c.int_type = int_edge_neg;
      write_cfg(p_neg, c);
      c.int_type = int_edge_both;
      write_cfg(p_both, c);
      add_wait(3);
      add_check(sel_int, '0);
      add_read(addr_int_status, '0);

      add_drive(pin_bit(p_pos));
      add_wait(4);
      add_check(sel_int, pin_bit(p_pos));
      add_check(sel_int_or, 32'h1);
      add_read(addr_int_status, pin_bit(p_pos));
      add_op(op_write, sel_out, addr_int_status, pin_bit(p_pos), '0, 3);
      add_check(sel_int, '0);
      add_wait(3);
      add_check(sel_int, '0);
      add_read(addr_int_status, '0);

      // rising input on the negative-edge pin raises nothing
      add_drive(pin_bit(p_pos) | pin_bit(p_neg));
      add_wait(4);
      add_check(sel_int, '0);
      add_drive(pin_bit(p_pos));
      add_wait(4);
      add_check(sel_int, pin_bit(p_neg));
      add_read(addr_int_status, pin_bit(p_neg));
      add_op(op_write, sel_out, addr_int_status, pin_bit(p_neg), '0, 3);
      add_check(sel_int, '0);

      add_drive(pin_bit(p_pos) | pin_bit(p_both));
      add_wait(4);
      add_check(sel_int, pin_bit(p_both));
      add_op(op_write, sel_out, addr_int_status, pin_bit(p_both), '0, 3);
      add_check(sel_int, '0);
      add_drive(pin_bit(p_pos));
      add_wait(4);
      add_check(sel_int, pin_bit(p_both));
      add_read(addr_int_status, pin_bit(p_both));
      add_op(op_write, sel_out, addr_int_status, pin_bit(p_both), '0, 3);
      add_check(sel_int, '0);
      add_op(op_end, sel_out, '0, 32'd4, '0, 0);

      // ----------------------------------------
      // level interrupts
      // ----------------------------------------
      add_drive('0);
      add_wait(4);
      disable_int(p_pos);
      disable_int(p_neg);
      disable_int(p_both);
      c = '0;
      c.in_en  = 1'b1;
      c.int_en = 1'b1;
      c.int_type = int_level_high;
      write_cfg(p_hi, c);
      c.int_type = int_level_low;
      write_cfg(p_lo, c);
      c.int_en = 1'b0;
      c.int_type = int_level_high;
      write_cfg(p_off, c);
      add_wait(2);
      add_check(sel_int, pin_bit(p_lo));
      add_read(addr_int_status, pin_bit(p_lo));

      add_drive(pin_bit(p_hi) | pin_bit(p_lo) | pin_bit(p_off));
      add_wait(4);
      add_check(sel_int, pin_bit(p_hi));
      add_check(sel_int_or, 32'h1);
      add_read(addr_int_status, pin_bit(p_hi));
      // level source sets the status again right after the clear
      add_op(op_write, sel_out, addr_int_status, pin_bit(p_hi), '0, 3);
      add_check(sel_int, pin_bit(p_hi));
      add_read(addr_int_status, pin_bit(p_hi));

      disable_int(p_hi);
      disable_int(p_lo);
      for (int k = 0; k < 4; k++)
      begin
         add_drive(next_rand());
         add_wait(4);
         add_check(sel_int, '0);
         add_check(sel_int_or, '0);
      end
      add_op(op_end, sel_out, '0, 32'd5, '0, 0);
   endfunction

   // ----------------------------------------
   // compare tasks
   // ----------------------------------------
   task automatic check_word(input logic [apb_data_w-1:0] got,
                             input logic [apb_data_w-1:0] exp, input string what);
      test_checks++;
      if (got !== exp)
      begin
         test_errors++;
         $display("mismatch at time %0t: %s got %08h, expected %08h", $time, what, got, exp);
      end
   endtask

   task automatic check_cfg(input pin_cfg_t got, input pin_cfg_t exp, input string what);
      test_checks++;
      if (got !== exp)
      begin
         test_errors++;
         $display("mismatch at time %0t: %s got %02h, expected %02h", $time, what, got, exp);
      end
   endtask

   // ----------------------------------------
   // APB transfers
   // ----------------------------------------
   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      @(posedge PCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge PCLK);
      penable <= 1'b1;
      @(negedge PCLK);
      check_word({30'h0, pready, pslverr}, 32'h2, "pready_o, pslverr_o");
      // write lands on this edge
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      @(posedge PCLK);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge PCLK);
      penable <= 1'b1;
      @(negedge PCLK);
      data = prdata;
      check_word({30'h0, pready, pslverr}, 32'h2, "pready_o, pslverr_o");
      @(posedge PCLK);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic run_entry(input entry_t e);
      logic [31:0] rd;
      case (e.op)
         op_write: apb_write(e.addr, e.data);
         op_read:
         begin
            apb_read(e.addr, rd);
            check_word(rd, e.exp, $sformatf("read at %02h", e.addr));
         end
         op_read_cfg:
         begin
            apb_read(e.addr, rd);
            check_cfg(pin_cfg_t'(rd[7:0]), pin_cfg_t'(e.exp[7:0]),
                      $sformatf("config at %02h", e.addr));
            // config byte is zero-extended to the bus width
            check_word(rd & 32'hffff_ff00, 32'h0,
                       $sformatf("config upper bits at %02h", e.addr));
         end
         op_drive:
         begin
            @(posedge PCLK);
            gpio_in <= e.data;
         end
         op_wait: repeat (int'(e.data)) @(posedge PCLK);
         op_check:
         begin
            @(negedge PCLK);
            case (e.sel)
               sel_out: check_word(gpio_out, e.exp, "gpio_out_o");
               sel_oe:  check_word(gpio_oe, e.exp, "gpio_oe_o");
               sel_int: check_word(int_vec, e.exp, "int_o");
               default: check_word({31'h0, int_or}, e.exp, "int_or_o");
            endcase
         end
         default:
         begin
            $display("test %0d %s: %0d checks, %0d errors",
                     e.data, test_names[e.data], test_checks, test_errors);
            total_checks += test_checks;
            total_errors += test_errors;
            test_checks = 0;
            test_errors = 0;
         end
      endcase
   endtask

   // ----------------------------------------
   // main sequence and watchdog
   // ----------------------------------------
   initial
   begin
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= '0;
      pwdata  <= '0;
      gpio_in <= '0;
      lcg_state = 32'h3da77520;
      build_table();
      // 2 reset cycles plus margin
      cycle_limit = table_cycles + 2 + 50;
      @(posedge aresetn);
      for (int n = 0; n < table_q.size(); n++)
         run_entry(table_q[n]);
      $display("total: %0d checks, %0d errors", total_checks, total_errors);
      if (total_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

   always @(posedge PCLK)
   begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt > cycle_limit)
      begin
         $display("timeout: table not finished after %0d cycles", cycle_limit);
         $display("Done: errors found");
         $finish;
      end
   end

endmodule

/* tb/gpio_apb_asserts.sv */
`timescale 1ns/1ps

module gpio_apb_asserts (
   input  logic                          PCLK,
   input  logic                          aresetn,
   input  logic                          pready_o,
   input  logic                          pslverr_o,
   input  logic [gpio_pkg::gpio_pins-1:0] gpio_oe_o,
   input  logic [gpio_pkg::gpio_pins-1:0] int_o,
   input  logic                          int_or_o,
   input  gpio_pkg::pin_stat_t           stat_i [gpio_pkg::gpio_pins]
);

   import gpio_pkg::*;

   logic [gpio_pins-1:0] out_en_vec;

   always_comb
   begin
      for (int i = 0; i < gpio_pins; i++)
         out_en_vec[i] = stat_i[i].cfg.out_en;
   end

   // ----------------------------------------
   // bus and pin properties
   // ----------------------------------------
   ready_high: assert property (@(posedge PCLK) disable iff (!aresetn) pready_o)
      else $error("pready_o went low");

   no_slverr: assert property (@(posedge PCLK) disable iff (!aresetn) !pslverr_o)
      else $error("pslverr_o went high");

   int_or_match: assert property (@(posedge PCLK) disable iff (!aresetn)
      int_or_o == (|int_o))
      else $error("int_or_o differs from the OR of int_o");

   // driver stays off where the output path is disabled
   oe_gated: assert property (@(posedge PCLK) disable iff (!aresetn)
      (gpio_oe_o & ~out_en_vec) == '0)
      else $error("gpio_oe_o set on a pin with out_en low");

endmodule

bind gpio_apb_top gpio_apb_asserts u_asserts (
   .PCLK      (PCLK),
   .aresetn   (aresetn),
   .pready_o  (pready_o),
   .pslverr_o (pslverr_o),
   .gpio_oe_o (gpio_oe_o),
   .int_o     (int_o),
   .int_or_o  (int_or_o),
   .stat_i    (pin_stat)
);

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic PCLK,
   output logic aresetn
);

   // 100 ns period, first rising edge at 50 ns
   initial
   begin
      PCLK = 1'b0;
      forever #50 PCLK = ~PCLK;
   end

   // low over two rising edges, released on a falling edge
   initial
   begin
      aresetn = 1'b0;
      #200 aresetn = 1'b1;
   end

endmodule

/* hdl/gpio_apb_top.sv */
`timescale 1ns/1ps

module gpio_apb_top (
   input  logic                               PCLK,
   input  logic                               aresetn,
   input  logic                               psel_i,
   input  logic                               penable_i,
   input  logic                               pwrite_i,
   input  logic [gpio_pkg::apb_addr_w-1:0]    paddr_i,
   input  logic [gpio_pkg::apb_data_w-1:0]    pwdata_i,
   output logic [gpio_pkg::apb_data_w-1:0]    prdata_o,
   output logic                               pready_o,
   output logic                               pslverr_o,
   input  logic [gpio_pkg::gpio_pins-1:0]     gpio_in_i,
   output logic [gpio_pkg::gpio_pins-1:0]     gpio_out_o,
   output logic [gpio_pkg::gpio_pins-1:0]     gpio_oe_o,
   output logic [gpio_pkg::gpio_pins-1:0]     int_o,
   output logic                               int_or_o
);

   import gpio_pkg::*;

   pin_wr_t   pin_wr   [gpio_pins];
   pin_stat_t pin_stat [gpio_pins];

   // zero wait states, never an error
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // ----------------------------------------
   // write decode
   // ----------------------------------------
   apb_reg_decode u_decode (
      .psel_i    (psel_i),
      .penable_i (penable_i),
      .pwrite_i  (pwrite_i),
      .paddr_i   (paddr_i),
      .pwdata_i  (pwdata_i),
      .pin_wr_o  (pin_wr)
   );

   // ----------------------------------------
   // pin cells
   // ----------------------------------------
   for (genvar i = 0; i < gpio_pins; i++)
   begin : g_pin
      gpio_pin_cell u_cell (
         .PCLK       (PCLK),
         .aresetn    (aresetn),
         .pin_wr_i   (pin_wr[i]),
         .gpio_in_i  (gpio_in_i[i]),
         .gpio_out_o (gpio_out_o[i]),
         .gpio_oe_o  (gpio_oe_o[i]),
         .int_o      (int_o[i]),
         .stat_o     (pin_stat[i])
      );
   end

   apb_read_mux u_read_mux (
      .paddr_i  (paddr_i),
      .stat_i   (pin_stat),
      .prdata_o (prdata_o)
   );

   assign int_or_o = |int_o;

endmodule

/* hdl/apb_read_mux.sv */
`timescale 1ns/1ps

module apb_read_mux (
   input  logic [gpio_pkg::apb_addr_w-1:0]  paddr_i,
   input  gpio_pkg::pin_stat_t              stat_i [gpio_pkg::gpio_pins],
   output logic [gpio_pkg::apb_data_w-1:0]  prdata_o
);

   import gpio_pkg::*;

   pin_cfg_t               cfg_sel;
   logic [gpio_pins-1:0]   int_word;
   logic [gpio_pins-1:0]   gpin_word;
   logic [gpio_pins-1:0]   gpout_word;

   // ----------------------------------------
   // gather per-pin bits
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pins; i++)
      begin
         int_word[i]   = stat_i[i].int_stat;
         gpin_word[i]  = stat_i[i].gpin_bit;
         gpout_word[i] = stat_i[i].gpout_bit;
      end
   end

   // only meaningful below the config limit, where bit 7 is clear
   assign cfg_sel = stat_i[paddr_i[6:2]].cfg;

   // ----------------------------------------
   // read data by address
   // ----------------------------------------
   always_comb
   begin
      if (paddr_i < addr_cfg_limit)
         prdata_o = {{(apb_data_w-8){1'b0}}, cfg_sel};
      else if (paddr_i == addr_int_status)
         prdata_o = int_word;
      else if (paddr_i == addr_gpin)
         prdata_o = gpin_word;
      else if (paddr_i == addr_gpout)
         prdata_o = gpout_word;
      else
         prdata_o = '0;
   end

endmodule

/* hdl/gpio_pin_cell.sv */
`timescale 1ns/1ps

module gpio_pin_cell (
   input  logic                PCLK,
   input  logic                aresetn,
   input  gpio_pkg::pin_wr_t   pin_wr_i,
   input  logic                gpio_in_i,
   output logic                gpio_out_o,
   output logic                gpio_oe_o,
   output logic                int_o,
   output gpio_pkg::pin_stat_t stat_o
);

   import gpio_pkg::*;

   pin_cfg_t cfg_q;

   // input pipeline
   logic gpin1_q;
   logic gpin2_q;
   logic gpin3_q;
   logic rise;
   logic fall;

   // sticky edge flags
   logic edge_pos_q;
   logic edge_neg_q;
   logic edge_both_q;

   logic int_sel;
   logic int_act;
   logic int_stat_q;
   logic gpout_q;

   // ----------------------------------------
   // configuration byte
   // ----------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         cfg_q <= '0;
      else if (pin_wr_i.cfg_we)
         cfg_q <= pin_wr_i.cfg;
   end

   // ----------------------------------------
   // input synchronizer
   // ----------------------------------------
   // two sync stages then one history stage
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpin1_q <= 1'b0;
         gpin2_q <= 1'b0;
         gpin3_q <= 1'b0;
      end
      else
      begin
         gpin1_q <= gpio_in_i;
         gpin2_q <= gpin1_q;
         gpin3_q <= gpin2_q;
      end
   end

   assign rise = gpin2_q & ~gpin3_q;
   assign fall = ~gpin2_q & gpin3_q;

   // ----------------------------------------
   // edge flags
   // ----------------------------------------
   // new edge wins over a clear in the same cycle
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_q  <= 1'b0;
         edge_neg_q  <= 1'b0;
         edge_both_q <= 1'b0;
      end
      else if (!cfg_q.int_en)
      begin
         edge_pos_q  <= 1'b0;
         edge_neg_q  <= 1'b0;
         edge_both_q <= 1'b0;
      end
      else
      begin
         if (rise)
            edge_pos_q <= 1'b1;
         else if (pin_wr_i.int_clr)
            edge_pos_q <= 1'b0;

         if (fall)
            edge_neg_q <= 1'b1;
         else if (pin_wr_i.int_clr)
            edge_neg_q <= 1'b0;

         if (rise | fall)
            edge_both_q <= 1'b1;
         else if (pin_wr_i.int_clr)
            edge_both_q <= 1'b0;
      end
   end

   // ----------------------------------------
   // interrupt select and status
   // ----------------------------------------
   always_comb
   begin
      case (cfg_q.int_type)
         int_level_high: int_sel = gpin3_q;
         int_level_low:  int_sel = ~gpin3_q;
         int_edge_pos:   int_sel = edge_pos_q;
         int_edge_neg:   int_sel = edge_neg_q;
         int_edge_both:  int_sel = edge_both_q;
         default:        int_sel = 1'b0;
      endcase
   end

   assign int_act = int_sel & cfg_q.int_en;

   // status trails int_o by one cycle
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         int_stat_q <= 1'b0;
      else if (pin_wr_i.int_clr)
         int_stat_q <= int_stat_q & ~pin_wr_i.int_clr;
      else
         int_stat_q <= int_act;
   end

   // ----------------------------------------
   // output register
   // ----------------------------------------
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         gpout_q <= gpout_reset_val[0];
      else if (pin_wr_i.out_we)
         gpout_q <= pin_wr_i.out_val;
   end

   assign gpio_out_o = gpout_q & cfg_q.out_en;
   // driver only on while the output path is enabled
   assign gpio_oe_o  = cfg_q.oe_en & cfg_q.out_en;
   assign int_o      = int_act;

   assign stat_o.cfg       = cfg_q;
   assign stat_o.gpin_bit  = gpin3_q & cfg_q.in_en;
   assign stat_o.int_stat  = int_stat_q;
   assign stat_o.gpout_bit = gpout_q;

endmodule

/* hdl/apb_reg_decode.sv */
`timescale 1ns/1ps

module apb_reg_decode (
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [gpio_pkg::apb_addr_w-1:0]   paddr_i,
   input  gpio_pkg::apb_wdata_u              pwdata_i,
   output gpio_pkg::pin_wr_t                 pin_wr_o [gpio_pkg::gpio_pins]
);

   import gpio_pkg::*;

   logic                  wr_access;
   logic                  cfg_hit;
   logic                  int_hit;
   logic                  out_hit;
   logic [apb_addr_w-3:0] pin_idx;

   // ----------------------------------------
   // transfer qualification
   // ----------------------------------------
   // access phase of a write, completes this cycle
   assign wr_access = psel_i & penable_i & pwrite_i;

   assign cfg_hit = wr_access && (paddr_i < addr_cfg_limit);
   assign int_hit = wr_access && (paddr_i == addr_int_status);
   assign out_hit = wr_access && (paddr_i == addr_gpout);

   // word index picks the pin
   assign pin_idx = paddr_i[apb_addr_w-1:2];

   // ----------------------------------------
   // per-pin commands
   // ----------------------------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pins; i++)
      begin
         // config byte path
         pin_wr_o[i].cfg_we  = cfg_hit && (int'(pin_idx) == i);
         pin_wr_o[i].cfg     = pwdata_i.cfg_w.cfg;

         // mask path, one bit per pin
         pin_wr_o[i].int_clr = int_hit & pwdata_i.mask[i];
         pin_wr_o[i].out_we  = out_hit;
         pin_wr_o[i].out_val = pwdata_i.mask[i];
      end
   end

endmodule

/* hdl/gpio_pkg.sv */
package gpio_pkg;

   // ----------------------------------------
   // sizes and register map
   // ----------------------------------------
   localparam int gpio_pins  = 32;
   localparam int apb_data_w = 32;
   localparam int apb_addr_w = 8;

   localparam logic [apb_addr_w-1:0] addr_int_status = 8'h80;
   localparam logic [apb_addr_w-1:0] addr_gpin       = 8'h90;
   localparam logic [apb_addr_w-1:0] addr_gpout      = 8'hA0;

   // config bytes live one per word below this address
   localparam logic [apb_addr_w-1:0] addr_cfg_limit  = 8'h80;

   // same value on every pin, so a cell can take bit 0
   localparam logic [gpio_pins-1:0] gpout_reset_val = {gpio_pins{1'b1}};

   // ----------------------------------------
   // interrupt types
   // ----------------------------------------
   // codes 5 to 7 raise nothing
   typedef enum logic [2:0] {
      int_level_high = 3'd0,
      int_level_low  = 3'd1,
      int_edge_pos   = 3'd2,
      int_edge_neg   = 3'd3,
      int_edge_both  = 3'd4
   } int_type_t;

   // per-pin config byte, bit 0 at the bottom
   typedef struct packed {
      int_type_t int_type;
      logic      spare;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // ----------------------------------------
   // bus and cell records
   // ----------------------------------------
   // write word seen as a config byte or as one bit per pin
   typedef union packed {
      logic [apb_data_w-1:0] mask;
      struct packed {
         logic [apb_data_w-9:0] pad;
         pin_cfg_t              cfg;
      } cfg_w;
   } apb_wdata_u;

   typedef struct packed {
      logic     cfg_we;
      pin_cfg_t cfg;
      logic     int_clr;
      logic     out_we;
      logic     out_val;
   } pin_wr_t;

   typedef struct packed {
      pin_cfg_t cfg;
      logic     gpin_bit;
      logic     int_stat;
      logic     gpout_bit;
   } pin_stat_t;

endpackage
